//--- asi_pkg.sv
package asi_pkg;

    // ------------------------------------------------------------------------
    // Micro-op encoding, class in the top two bits
    // ------------------------------------------------------------------------

    typedef enum logic [4:0] {
        aessub_enc    = 5'b01_000,   // bit 0 set = decrypt, bit 1 set = rotate
        aessub_encrot = 5'b01_010,
        aessub_dec    = 5'b01_001,
        aessub_decrot = 5'b01_011,
        aesmix_enc    = 5'b01_100,   // bit 2 picks MixColumns
        aesmix_dec    = 5'b01_101,
        sha256_s0     = 5'b10_000,   // Low bits give sigma number
        sha256_s1     = 5'b10_001,
        sha256_s2     = 5'b10_010,
        sha256_s3     = 5'b10_011,
        sha3_xy       = 5'b11_000,
        sha3_x1       = 5'b11_001,
        sha3_x2       = 5'b11_010,
        sha3_x4       = 5'b11_011,
        sha3_yx       = 5'b11_100
    } asi_uop_e;

    typedef enum logic [1:0] {
        cls_aes  = 2'b01,
        cls_sha2 = 2'b10,
        cls_sha3 = 2'b11
    } asi_class_e;

    // Byte-serial AES unit FSM
    typedef enum logic [1:0] {
        idle   = 2'd0,
        busy   = 2'd1,
        finish = 2'd2
    } asi_fsm_e;

    typedef struct packed {
        asi_uop_e    uop;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [1:0]  shamt;   // Post-shift for SHA-3 index
    } asi_req_t;

    // ------------------------------------------------------------------------
    // GF(2^8) arithmetic, polynomial x^8 + x^4 + x^3 + x + 1
    // ------------------------------------------------------------------------

    function automatic logic [7:0] aes_xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] rotl8(input logic [7:0] b, input int unsigned n);
        return (b << n) | (b >> (8 - n));
    endfunction

    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] p;
        acc = 8'h00;
        p   = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) acc = acc ^ p;   // Shift-and-add
            p = aes_xtime(p);
        end
        return acc;
    endfunction

    // Inverse as a^254, zero maps to zero
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] sq;
        logic [7:0] acc;
        sq  = a;
        acc = 8'h01;
        for (int i = 1; i < 8; i++) begin
            sq  = gf_mul(sq, sq);    // a^(2^i)
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    function automatic logic [7:0] aes_sbox_fwd(input logic [7:0] b);
        logic [7:0] v;
        v = gf_inv(b);
        return v ^ rotl8(v, 1) ^ rotl8(v, 2) ^ rotl8(v, 3) ^ rotl8(v, 4) ^ 8'h63;
    endfunction

    function automatic logic [7:0] aes_sbox_inv(input logic [7:0] b);
        logic [7:0] v;
        v = rotl8(b, 1) ^ rotl8(b, 3) ^ rotl8(b, 6) ^ 8'h05;   // Undo affine map first
        return gf_inv(v);
    endfunction

endpackage

//--- asi_sha256.sv
`timescale 1ns/1ns

module asi_sha256 (
    input  logic [31:0] rs1,
    input  logic [1:0]  ss,       // Which sigma
    output logic [31:0] result
);

    function automatic logic [31:0] rotr(input logic [31:0] w, input int unsigned n);
        return (w >> n) | (w << (32 - n));
    endfunction

    // Small sigmas for message schedule, big ones for compression
    always_comb begin
        case (ss)
            2'd0: begin
                result = rotr(rs1, 7) ^ rotr(rs1, 18) ^ (rs1 >> 3);     // sigma0
            end
            2'd1: begin
                result = rotr(rs1, 17) ^ rotr(rs1, 19) ^ (rs1 >> 10);   // sigma1
            end
            2'd2: begin
                result = rotr(rs1, 2) ^ rotr(rs1, 13) ^ rotr(rs1, 22);  // Sigma0
            end
            default: begin
                result = rotr(rs1, 6) ^ rotr(rs1, 11) ^ rotr(rs1, 25);  // Sigma1
            end
        endcase
    end

endmodule

//--- asi_sha3.sv
`timescale 1ns/1ns

module asi_sha3 (
    input  logic [31:0] rs1,
    input  logic [31:0] rs2,
    input  logic [1:0]  shamt,    // Post-shift of lane index
    input  logic [4:0]  fn,       // One-hot xy, x1, x2, x4, yx
    output logic [31:0] result
);

    logic [2:0] x;
    logic [2:0] y;
    logic [2:0] x_p1;
    logic [2:0] x_p2;
    logic [2:0] x_p4;
    logic [2:0] t_yx;     // (2x + 3y) mod 5
    logic [4:0] idx;

    // Lane index within the 5x5 state
    function automatic logic [4:0] lane(input logic [2:0] a, input logic [2:0] b);
        return 5'(a) + 5'(b) * 5'd5;
    endfunction

    assign x = 3'(rs1 % 32'd5);
    assign y = 3'(rs2 % 32'd5);

    assign x_p1 = 3'((4'(x) + 4'd1) % 4'd5);
    assign x_p2 = 3'((4'(x) + 4'd2) % 4'd5);
    assign x_p4 = 3'((4'(x) + 4'd4) % 4'd5);
    assign t_yx = 3'((5'(x) * 5'd2 + 5'(y) * 5'd3) % 5'd5);

    always_comb begin
        idx = ({5{fn[0]}} & lane(x, y))    |
              ({5{fn[1]}} & lane(x_p1, y)) |
              ({5{fn[2]}} & lane(x_p2, y)) |
              ({5{fn[3]}} & lane(x_p4, y)) |
              ({5{fn[4]}} & lane(y, t_yx));   // Rho-pi style swap
    end

    // Index at most 24, shifted by up to 3 still fits a byte
    assign result = {24'b0, 8'(idx) << shamt};

endmodule

//--- asi_aessub.sv
`timescale 1ns/1ns

module asi_aessub (
    input  logic        g_clk,
    input  logic        rst,
    input  logic        start,    // Level, drop to abort
    input  logic        enc,      // Forward S-box when set
    input  logic        rot,      // Rotate result left one byte
    input  logic [31:0] rs1,
    input  logic [31:0] rs2,
    output logic        done,     // One-cycle pulse
    output logic [31:0] result
);
    import asi_pkg::*;

    asi_fsm_e    state;
    logic [1:0]  cnt;         // Byte being substituted
    logic [31:0] in_word;
    logic [7:0]  sbox_in;
    logic [7:0]  sbox_out;
    logic        take;        // Write a byte this cycle
    logic [31:0] res_q;

    // ------------------------------------------------------------------------
    // Byte path through the single S-box
    // ------------------------------------------------------------------------

    assign in_word  = {rs2[31:16], rs1[15:0]};    // Two half-words of state
    assign sbox_in  = in_word[{cnt, 3'b000} +: 8];
    assign sbox_out = enc ? aes_sbox_fwd(sbox_in) : aes_sbox_inv(sbox_in);

    // Byte 0 goes in the same cycle as start
    assign take = start && ((state == idle) || (state == busy));

    always_ff @(posedge g_clk) begin
        if (take) begin
            res_q[{cnt, 3'b000} +: 8] <= sbox_out;
        end
    end

    // ------------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (rst) begin
            state <= idle;
            cnt   <= 2'd0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= busy;
                        cnt   <= cnt + 2'd1;
                    end
                end
                busy: begin
                    if (!start) begin
                        state <= idle;    // Abort
                        cnt   <= 2'd0;
                    end else begin
                        cnt <= cnt + 2'd1;            // Wraps to 0 after byte 3
                        if (cnt == 2'd3) begin
                            state <= finish;
                        end
                    end
                end
                finish: begin
                    state <= idle;        // Free again next cycle
                    cnt   <= 2'd0;
                end
                default: begin
                    state <= idle;
                    cnt   <= 2'd0;
                end
            endcase
        end
    end

    assign done = (state == finish);

    // Optional byte rotation applied on the way out
    always_comb begin
        if (!done) begin
            result = 32'b0;
        end else if (rot) begin
            result = {res_q[23:0], res_q[31:24]};
        end else begin
            result = res_q;
        end
    end

endmodule

//--- asi_aesmix.sv
`timescale 1ns/1ns

module asi_aesmix (
    input  logic        g_clk,
    input  logic        rst,
    input  logic        start,    // Level, drop to abort
    input  logic        enc,      // Forward MixColumns when set
    input  logic [31:0] rs1,      // One column, byte 0 is row 0
    output logic        done,
    output logic [31:0] result
);
    import asi_pkg::*;

    asi_fsm_e        state;
    logic [1:0]      cnt;     // Output row
    logic [63:0]     dbl;     // Column twice, for wrap-around select
    logic [3:0][7:0] b;       // Column rotated so current row is b[0]
    logic [3:0][7:0] b2;
    logic [3:0][7:0] b4;
    logic [3:0][7:0] b8;
    logic [7:0]      row;
    logic [31:0]     res_q;

    assign dbl = {rs1, rs1};
    assign b   = dbl[{cnt, 3'b000} +: 32];

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            b2[k] = aes_xtime(b[k]);
            b4[k] = aes_xtime(b2[k]);
            b8[k] = aes_xtime(b4[k]);
        end
        if (enc) begin
            row = b2[0] ^ (b2[1] ^ b[1]) ^ b[2] ^ b[3];                  // 2 3 1 1
        end else begin
            row = (b8[0] ^ b4[0] ^ b2[0]) ^ (b8[1] ^ b2[1] ^ b[1]) ^     // 14 11
                  (b8[2] ^ b4[2] ^ b[2]) ^ (b8[3] ^ b[3]);               // 13 9
        end
    end

    always_ff @(posedge g_clk) begin
        if (start && ((state == idle) || (state == busy))) begin
            res_q[{cnt, 3'b000} +: 8] <= row;
        end
    end

    // Same sequencing as SubBytes: four bytes, then a done cycle
    always_ff @(posedge g_clk) begin
        if (rst) begin
            state <= idle;
            cnt   <= 2'd0;
        end else if ((state == finish) || !start) begin
            state <= idle;
            cnt   <= 2'd0;
        end else begin
            cnt <= cnt + 2'd1;
            if (cnt == 2'd3) begin
                state <= finish;
            end else begin
                state <= busy;
            end
        end
    end

    assign done   = (state == finish);
    assign result = done ? res_q : 32'b0;

endmodule

//--- asi_ctrl.sv
`timescale 1ns/1ns

module asi_ctrl (
    input  logic              g_clk,
    input  logic              rst,
    input  logic              valid,        // Held until ready
    input  logic              flush,        // Abandon current op
    input  asi_pkg::asi_req_t req,
    output logic [31:0]       sha2_rs1,
    output logic [1:0]        sha2_ss,
    output logic [4:0]        sha3_fn,      // One-hot
    output logic              sub_start,
    output logic              sub_enc,
    output logic              sub_rot,
    output logic              mix_start,
    output logic              mix_enc,
    input  logic              sub_done,
    input  logic [31:0]       sub_result,
    input  logic              mix_done,
    input  logic [31:0]       mix_result,
    input  logic [31:0]       sha2_result,
    input  logic [31:0]       sha3_result,
    output logic              ready,        // One-cycle pulse
    output logic [31:0]       result
);
    import asi_pkg::*;

    asi_class_e cls;
    logic       accept;         // Valid and not being flushed
    logic       flush_q;        // Flush seen last cycle
    logic       insn_aes;
    logic       insn_sub;
    logic       insn_mix;
    logic       insn_sha2;
    logic       insn_sha3;
    logic       sub_ready;
    logic       mix_ready;

    // ------------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------------

    assign cls    = asi_class_e'(req.uop[4:3]);
    assign accept = valid && !flush;

    assign insn_aes  = accept && (cls == cls_aes);
    assign insn_sub  = insn_aes && !req.uop[2];
    assign insn_mix  = insn_aes &&  req.uop[2];
    assign insn_sha2 = accept && (cls == cls_sha2);
    assign insn_sha3 = accept && (cls == cls_sha3);

    assign sha3_fn[0] = accept && (req.uop == sha3_xy);
    assign sha3_fn[1] = accept && (req.uop == sha3_x1);
    assign sha3_fn[2] = accept && (req.uop == sha3_x2);
    assign sha3_fn[3] = accept && (req.uop == sha3_x4);
    assign sha3_fn[4] = accept && (req.uop == sha3_yx);

    // Keeps both AES units parked for a cycle after flush
    always_ff @(posedge g_clk) begin
        if (rst) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= flush;
        end
    end

    // ------------------------------------------------------------------------
    // Operand gating and unit controls
    // ------------------------------------------------------------------------

    assign sha2_rs1  = {32{insn_sha2}} & req.rs1;   // Quiet when unused
    assign sha2_ss   = req.uop[1:0];

    assign sub_start = insn_sub && !flush_q;        // Low level aborts
    assign sub_enc   = !req.uop[0];
    assign sub_rot   =  req.uop[1];

    assign mix_start = insn_mix && !flush_q;
    assign mix_enc   = !req.uop[0];

    // ------------------------------------------------------------------------
    // Result select and ready
    // ------------------------------------------------------------------------

    assign sub_ready = sub_start && sub_done;
    assign mix_ready = mix_start && mix_done;

    assign ready = insn_sha2 || insn_sha3 || sub_ready || mix_ready;

    assign result = ({32{insn_sha2}} & sha2_result) |
                    ({32{insn_sha3}} & sha3_result) |
                    ({32{sub_ready}} & sub_result)  |
                    ({32{mix_ready}} & mix_result);

endmodule

//--- asi_top.sv
`timescale 1ns/1ns

module asi_top (
    input  logic              g_clk,
    input  logic              rst,
    input  logic              valid,
    input  logic              flush,
    input  asi_pkg::asi_req_t req,
    output logic              ready,
    output logic [31:0]       result
);

    logic [31:0] sha2_rs1;
    logic [1:0]  sha2_ss;
    logic [4:0]  sha3_fn;
    logic        sub_start;
    logic        sub_enc;
    logic        sub_rot;
    logic        mix_start;
    logic        mix_enc;
    logic        sub_done;
    logic [31:0] sub_result;
    logic        mix_done;
    logic [31:0] mix_result;
    logic [31:0] sha2_result;
    logic [31:0] sha3_result;

    // ------------------------------------------------------------------------
    // Decode, gating and result mux
    // ------------------------------------------------------------------------

    asi_ctrl asi_ctrl_i (
        .g_clk      (g_clk),
        .rst        (rst),
        .valid      (valid),
        .flush      (flush),
        .req        (req),
        .sha2_rs1   (sha2_rs1),
        .sha2_ss    (sha2_ss),
        .sha3_fn    (sha3_fn),
        .sub_start  (sub_start),
        .sub_enc    (sub_enc),
        .sub_rot    (sub_rot),
        .mix_start  (mix_start),
        .mix_enc    (mix_enc),
        .sub_done   (sub_done),
        .sub_result (sub_result),
        .mix_done   (mix_done),
        .mix_result (mix_result),
        .sha2_result(sha2_result),
        .sha3_result(sha3_result),
        .ready      (ready),
        .result     (result)
    );

    // ------------------------------------------------------------------------
    // Datapaths
    // ------------------------------------------------------------------------

    asi_sha256 asi_sha256_i (
        .rs1   (sha2_rs1),       // Already gated
        .ss    (sha2_ss),
        .result(sha2_result)
    );

    asi_sha3 asi_sha3_i (
        .rs1   (req.rs1),
        .rs2   (req.rs2),
        .shamt (req.shamt),
        .fn    (sha3_fn),        // All zero when idle
        .result(sha3_result)
    );

    asi_aessub asi_aessub_i (
        .g_clk (g_clk),
        .rst   (rst),
        .start (sub_start),
        .enc   (sub_enc),
        .rot   (sub_rot),
        .rs1   (req.rs1),
        .rs2   (req.rs2),
        .done  (sub_done),
        .result(sub_result)
    );

    asi_aesmix asi_aesmix_i (
        .g_clk (g_clk),
        .rst   (rst),
        .start (mix_start),
        .enc   (mix_enc),
        .rs1   (req.rs1),        // Single column
        .done  (mix_done),
        .result(mix_result)
    );

endmodule

//--- asi_assertions.sv
`timescale 1ns/1ns

module asi_assertions (
    input logic              g_clk,
    input logic              rst,
    input logic              valid,
    input asi_pkg::asi_req_t req,
    input logic              ready
);
    import asi_pkg::*;

    int   fail_cnt = 0;     // Assertion failures so far
    logic aes_ready;

    assign aes_ready = ready && (req.uop[4:3] == cls_aes);

    // No result without a request held through the whole AES op
    ready_needs_valid: assert property (@(posedge g_clk) disable iff (rst)
                                        ready |-> valid && (!aes_ready ||
                                        ($past(valid, 1) && $past(valid, 2) &&
                                         $past(valid, 3) && $past(valid, 4))))
        else begin
            $error("ready high without valid held for the operation");
            fail_cnt = fail_cnt + 1;
        end

    // AES units pulse done once, then sit idle a cycle
    aes_ready_single: assert property (@(posedge g_clk) disable iff (rst)
                                       aes_ready |=> !aes_ready)
        else begin
            $error("AES ready high in two consecutive cycles");
            fail_cnt = fail_cnt + 1;
        end

    ready_low_after_rst: assert property (@(posedge g_clk) rst |=> !ready)
        else begin
            $error("ready high in the cycle after reset");
            fail_cnt = fail_cnt + 1;
        end

endmodule

bind asi_top asi_assertions asi_assertions_i (
    .g_clk(g_clk),
    .rst  (rst),
    .valid(valid),
    .req  (req),
    .ready(ready)
);

//--- tb_asi.sv
`timescale 1ns/1ns

module tb_asi;
    import asi_pkg::*;

    localparam int n_sha2  = 50;       // Words per sigma
    localparam int n_sha3  = 20;       // Requests per index function
    localparam int n_sub   = 10;       // Requests per SubBytes uop
    localparam int n_mix   = 8;        // Columns, each forward then inverse
    localparam int aes_lat = 4;
    localparam int n_req   = 4 * n_sha2 + 5 * n_sha3 + 4 * n_sub + 2 * n_mix + 7;
    localparam int max_cyc = 16 + 6 * n_req + 200;

    logic        g_clk;
    logic        rst;
    logic        valid;
    logic        flush;
    asi_req_t    req;
    logic        ready;
    logic [31:0] result;

    logic [31:0] lfsr_q  = 32'ha378;
    int          cyc_cnt = 0;
    logic [7:0]  sbox_tab  [256];     // Forward S-box model
    logic [7:0]  isbox_tab [256];

    asi_top asi_top_i (
        .g_clk (g_clk),
        .rst   (rst),
        .valid (valid),
        .flush (flush),
        .req   (req),
        .ready (ready),
        .result(result)
    );

    initial begin
        g_clk = 1'b0;
        forever #50 g_clk = ~g_clk;
    end

    always @(posedge g_clk) begin
        cyc_cnt++;
        if (cyc_cnt > max_cyc) begin
            $display("Timeout, run passed %0d cycles", cyc_cnt);
            stop_fail();
        end else if (asi_top_i.asi_assertions_i.fail_cnt != 0) begin
            $display("A bound assertion on the DUT failed");
            stop_fail();
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus source and reference models
    // ------------------------------------------------------------------------

    // Taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = 32'b0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);     // One step per bit
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Carry-less product, then reduce by 0x11b
    function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
        logic [15:0] p;
        p = 16'b0;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) p = p ^ (16'(a) << i);
        end
        for (int i = 15; i >= 8; i--) begin
            if (p[i]) p = p ^ (16'h011b << (i - 8));
        end
        return p[7:0];
    endfunction

    function automatic logic [7:0] affine(input logic [7:0] v);
        logic [7:0] s;
        for (int i = 0; i < 8; i++) begin
            s[i] = v[i] ^ v[(i + 4) % 8] ^ v[(i + 5) % 8] ^ v[(i + 6) % 8] ^ v[(i + 7) % 8];
        end
        return s ^ 8'h63;
    endfunction

    // Inverse found by search over all bytes
    task automatic build_sbox();
        logic [7:0] inv;
        for (int a = 0; a < 256; a++) begin
            inv = 8'h00;
            for (int c = 1; c < 256; c++) begin
                if (gmul(8'(a), 8'(c)) == 8'h01) inv = 8'(c);
            end
            sbox_tab[a]            = affine(inv);
            isbox_tab[affine(inv)] = 8'(a);
        end
    endtask

    function automatic logic [31:0] rotr(input logic [31:0] w, input int n);
        logic [63:0] d;
        d = {w, w} >> n;
        return d[31:0];
    endfunction

    function automatic logic [31:0] sha2_model(input int ss, input logic [31:0] w);
        case (ss)
            0:       return rotr(w, 7) ^ rotr(w, 18) ^ (w >> 3);
            1:       return rotr(w, 17) ^ rotr(w, 19) ^ (w >> 10);
            2:       return rotr(w, 2) ^ rotr(w, 13) ^ rotr(w, 22);
            default: return rotr(w, 6) ^ rotr(w, 11) ^ rotr(w, 25);
        endcase
    endfunction

    function automatic logic [31:0] sha3_model(input asi_req_t r);
        int x;
        int y;
        int idx;
        x = int'(r.rs1 % 32'd5);
        y = int'(r.rs2 % 32'd5);
        case (r.uop)
            sha3_x1: idx = (x + 1) % 5 + 5 * y;
            sha3_x2: idx = (x + 2) % 5 + 5 * y;
            sha3_x4: idx = (x + 4) % 5 + 5 * y;
            sha3_yx: idx = y + 5 * ((2 * x + 3 * y) % 5);
            default: idx = x + 5 * y;
        endcase
        return 32'(idx << r.shamt);
    endfunction

    function automatic logic [31:0] sub_model(input asi_req_t r);
        logic [31:0] w;
        logic [31:0] o;
        logic        fwd;
        w   = {r.rs2[31:16], r.rs1[15:0]};
        fwd = (r.uop == aessub_enc) || (r.uop == aessub_encrot);
        for (int i = 0; i < 4; i++) begin
            o[8*i +: 8] = fwd ? sbox_tab[w[8*i +: 8]] : isbox_tab[w[8*i +: 8]];
        end
        if ((r.uop == aessub_encrot) || (r.uop == aessub_decrot)) begin
            o = {o[23:0], o[31:24]};         // Rotate left one byte
        end
        return o;
    endfunction

    function automatic logic [31:0] mix_model(input logic [31:0] col, input logic fwd);
        logic [7:0]  a [4];
        logic [7:0]  k [4];
        logic [31:0] o;
        for (int i = 0; i < 4; i++) begin
            a[i] = col[8*i +: 8];
        end
        if (fwd) begin
            k = '{8'd2, 8'd3, 8'd1, 8'd1};
        end else begin
            k = '{8'd14, 8'd11, 8'd13, 8'd9};
        end
        for (int i = 0; i < 4; i++) begin
            o[8*i +: 8] = gmul(k[0], a[i]) ^ gmul(k[1], a[(i + 1) % 4]) ^
                          gmul(k[2], a[(i + 2) % 4]) ^ gmul(k[3], a[(i + 3) % 4]);
        end
        return o;
    endfunction

    // ------------------------------------------------------------------------
    // Checks and request driver
    // ------------------------------------------------------------------------

    task automatic stop_fail();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("Error: time %0t %s expected %08h actual %08h", $time, name, exp, act);
            stop_fail();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: time %0t %s expected %b actual %b", $time, name, exp, act);
            stop_fail();
        end
    endtask

    task automatic check_lat(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Error: time %0t %s expected %0d actual %0d", $time, name, exp, act);
            stop_fail();
        end
    endtask

    function automatic asi_req_t mk_req(input asi_uop_e u, input logic [31:0] a,
                                        input logic [31:0] b, input logic [1:0] sh);
        asi_req_t r;
        r.uop   = u;
        r.rs1   = a;
        r.rs2   = b;
        r.shamt = sh;
        return r;
    endfunction

    // Count cycles from the current request until ready
    task automatic wait_ready(output logic [31:0] res, output int lat);
        lat = 0;
        @(negedge g_clk);
        while (ready !== 1'b1) begin
            lat++;
            if (lat > 2 * aes_lat) begin
                $display("No ready seen %0d cycles after valid", lat);
                stop_fail();
            end
            @(negedge g_clk);
        end
        res = result;                         // Only good in the ready cycle
    endtask

    // Hold valid until ready and drop it afterwards
    task automatic run_req(input asi_req_t r, output logic [31:0] res, output int lat);
        @(posedge g_clk);
        #10;
        valid = 1'b1;
        req   = r;
        wait_ready(res, lat);
        @(posedge g_clk);
        #10;
        valid = 1'b0;
        req   = '0;
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------

    task automatic test_idle();
        for (int c = 0; c < 3; c++) begin
            @(negedge g_clk);
            check_bit("ready", 1'b0, ready);
            check_word("result", 32'h0, result);
            @(posedge g_clk);
            #10;
            req = mk_req(sha3_yx, take_bits(32), take_bits(32), 2'(take_bits(2)));
        end
        req = '0;
    endtask

    task automatic test_sha2();
        asi_uop_e    ops [4];
        asi_req_t    r;
        logic [31:0] res;
        int          lat;
        ops = '{sha256_s0, sha256_s1, sha256_s2, sha256_s3};
        for (int f = 0; f < 4; f++) begin
            for (int n = 0; n < n_sha2; n++) begin
                r = mk_req(ops[f], take_bits(32), take_bits(32), 2'b00);
                run_req(r, res, lat);
                check_word("result", sha2_model(f, r.rs1), res);
                check_lat("ready latency", 0, lat);
            end
        end
    endtask

    task automatic test_sha3();
        asi_uop_e    ops [5];
        asi_req_t    r;
        logic [31:0] res;
        int          lat;
        ops = '{sha3_xy, sha3_x1, sha3_x2, sha3_x4, sha3_yx};
        for (int f = 0; f < 5; f++) begin
            for (int n = 0; n < n_sha3; n++) begin
                r = mk_req(ops[f], take_bits(32), take_bits(32), 2'(take_bits(2)));
                run_req(r, res, lat);
                check_word("result", sha3_model(r), res);
                check_lat("ready latency", 0, lat);
            end
        end
    endtask

    task automatic test_sub();
        asi_uop_e    ops [4];
        asi_req_t    r;
        logic [31:0] res;
        int          lat;
        ops = '{aessub_enc, aessub_encrot, aessub_dec, aessub_decrot};
        for (int f = 0; f < 4; f++) begin
            for (int n = 0; n < n_sub; n++) begin
                r = mk_req(ops[f], take_bits(32), take_bits(32), 2'b00);
                run_req(r, res, lat);
                check_word("result", sub_model(r), res);
                check_lat("ready latency", aes_lat, lat);
            end
        end
    endtask

    // Forward then inverse must give the column back
    task automatic test_mix();
        logic [31:0] col;
        logic [31:0] fwd_res;
        logic [31:0] inv_res;
        int          lat;
        for (int n = 0; n < n_mix; n++) begin
            col = take_bits(32);
            run_req(mk_req(aesmix_enc, col, 32'h0, 2'b00), fwd_res, lat);
            check_word("result", mix_model(col, 1'b1), fwd_res);
            check_lat("ready latency", aes_lat, lat);
            run_req(mk_req(aesmix_dec, fwd_res, 32'h0, 2'b00), inv_res, lat);
            check_word("result", mix_model(fwd_res, 1'b0), inv_res);
            check_lat("ready latency", aes_lat, lat);
            check_word("round trip column", col, inv_res);
        end
    endtask

    task automatic test_flush();
        asi_req_t    r;
        logic [31:0] res;
        int          lat;
        r = mk_req(aessub_enc, take_bits(32), take_bits(32), 2'b00);
        @(posedge g_clk);
        #10;
        valid = 1'b1;
        req   = r;
        for (int c = 0; c < 6; c++) begin
            @(negedge g_clk);
            check_bit("ready", 1'b0, ready);  // Abandoned op stays silent
            @(posedge g_clk);
            #10;
            if (c == 3) flush = 1'b1;         // Lands in the cycle ready would rise
            if (c == 4) begin
                flush = 1'b0;
                valid = 1'b0;
                req   = '0;
            end
        end
        r = mk_req(sha256_s2, take_bits(32), take_bits(32), 2'b00);
        run_req(r, res, lat);
        check_word("result", sha2_model(2, r.rs1), res);
        check_lat("ready latency", 0, lat);
        r = mk_req(aessub_decrot, take_bits(32), take_bits(32), 2'b00);
        run_req(r, res, lat);
        check_word("result", sub_model(r), res);
        check_lat("ready latency", aes_lat, lat);
    endtask

    // Next request enters in the cycle after ready while valid stays high
    task automatic test_back_to_back();
        asi_req_t    r [4];
        logic [31:0] exp;
        logic [31:0] res;
        int          lat;
        r[0] = mk_req(aessub_encrot, take_bits(32), take_bits(32), 2'b00);
        r[1] = mk_req(aessub_dec, take_bits(32), take_bits(32), 2'b00);
        r[2] = mk_req(aesmix_enc, take_bits(32), 32'h0, 2'b00);
        r[3] = mk_req(aesmix_dec, take_bits(32), 32'h0, 2'b00);
        @(posedge g_clk);
        #10;
        valid = 1'b1;
        for (int i = 0; i < 4; i++) begin
            req = r[i];
            wait_ready(res, lat);
            if (i < 2) begin
                exp = sub_model(r[i]);
            end else begin
                exp = mix_model(r[i].rs1, i == 2);
            end
            check_word("result", exp, res);
            check_lat("ready latency", aes_lat, lat);
            @(posedge g_clk);
            #10;
        end
        valid = 1'b0;
        req   = '0;
    endtask

    // Reset hits the last byte cycle, the op then restarts from byte 0
    task automatic test_reset();
        asi_req_t    r;
        logic [31:0] res;
        int          lat;
        r = mk_req(aesmix_dec, take_bits(32), 32'h0, 2'b00);
        @(posedge g_clk);
        #10;
        valid = 1'b1;
        req   = r;
        repeat (3) @(posedge g_clk);
        #10;
        rst = 1'b1;
        @(posedge g_clk);
        #10;
        rst = 1'b0;
        wait_ready(res, lat);
        check_word("result", mix_model(r.rs1, 1'b0), res);
        check_lat("ready latency", aes_lat, lat);
        @(posedge g_clk);
        #10;
        valid = 1'b0;
        req   = '0;
    endtask

    initial begin
        rst   = 1'b1;
        valid = 1'b0;
        flush = 1'b0;
        req   = '0;
        build_sbox();
        repeat (16) @(posedge g_clk);
        #10;
        rst = 1'b0;
        test_idle();
        test_sha2();
        test_sha3();
        test_sub();
        test_mix();
        test_flush();
        test_back_to_back();
        test_reset();
        test_idle();
        @(posedge g_clk);
        if (asi_top_i.asi_assertions_i.fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("%0d assertion failures", asi_top_i.asi_assertions_i.fail_cnt);
            stop_fail();
        end
    end

endmodule

//--- files.f
asi_pkg.sv
asi_sha256.sv
asi_sha3.sv
asi_aessub.sv
asi_aesmix.sv
asi_ctrl.sv
asi_top.sv
asi_assertions.sv
tb_asi.sv
